// ==== bench/exec_trace.txt ====
# op_a op_b rs rt rd imm shamt alu_op shift_op exres_sel reg_w ovf_dis imm_sel shamt_sel cmov
# then expected data reg_w rd overflow, every column in hex
00000005 00000003 01 02 03 00000000 00 0 0 0 1 1 0 0 0 00000008 1 03 0
ffffffff 00000001 04 05 06 00000000 00 1 0 0 1 1 0 0 0 00000000 1 06 0
00000010 00000003 07 08 09 00000000 00 2 0 0 1 1 0 0 0 0000000d 1 09 0
00000000 00000001 0a 0b 0c 00000000 00 3 0 0 1 1 0 0 0 ffffffff 1 0c 0
f0f0f0f0 0ff00ff0 0d 0e 0f 00000000 00 4 0 0 1 0 0 0 0 00f000f0 1 0f 0
f0f0f0f0 0ff00ff0 10 11 12 00000000 00 5 0 0 1 0 0 0 0 fff0fff0 1 12 0
f0f0f0f0 0ff00ff0 13 14 15 00000000 00 6 0 0 1 0 0 0 0 ff00ff00 1 15 0
12345678 00000000 16 17 18 00000000 00 7 0 0 1 0 0 0 0 edcba987 1 18 0
80000000 7fffffff 19 1a 1b 00000000 00 8 0 0 1 0 0 0 0 00000001 1 1b 0
80000000 7fffffff 1c 1d 1e 00000000 00 9 0 0 1 0 0 0 0 00000000 1 1e 0
ffffffff 00000000 01 02 1f 00000000 00 8 0 0 1 0 0 0 0 00000001 1 1f 0
ffffffff 00000000 03 04 01 00000000 00 9 0 0 1 0 0 0 0 00000000 1 01 0
00000000 00000000 00 00 02 00001234 00 a 0 0 1 0 1 0 0 12340000 1 02 0
00000100 00000000 05 06 07 fffffff0 00 0 0 0 1 1 1 0 0 000000f0 1 07 0
00000000 00000001 00 08 09 00000000 04 1 0 1 1 0 0 0 0 00000010 1 09 0
00000000 80000000 00 0a 0b 00000000 1f 1 1 1 1 0 0 0 0 00000001 1 0b 0
00000000 80000000 00 0c 0d 00000000 04 1 2 1 1 0 0 0 0 f8000000 1 0d 0
00000000 7ffffff0 00 0e 0f 00000000 04 1 2 1 1 0 0 0 0 07ffffff 1 0f 0
00000023 0000000f 10 11 12 00000000 00 1 0 1 1 0 0 1 0 00000078 1 12 0
00000008 87654321 13 14 15 00000000 00 1 2 1 1 0 0 1 0 ff876543 1 15 0
0000001c f0000000 16 17 18 00000000 00 1 1 1 1 0 0 1 0 0000000f 1 18 0
7fffffff 00000001 19 1a 1b 00000000 00 0 0 0 1 1 0 0 0 80000000 0 1b 1
80000000 00000001 1c 1d 1e 00000000 00 2 0 0 1 0 0 0 0 7fffffff 1 1e 1
7fffffff 00000001 01 02 03 00000000 00 1 0 0 1 1 0 0 0 80000000 1 03 0
11111111 00000005 03 04 05 00000000 00 1 0 0 1 0 0 0 0 80000005 1 05 0
00000010 22222222 06 05 07 00000000 00 3 0 0 1 0 0 0 0 8000000b 1 07 0
00000000 00000000 07 07 08 00000000 00 1 0 0 1 0 0 0 0 00000016 1 08 0
00000033 00000000 09 0a 00 00000000 00 1 0 0 1 0 0 0 0 00000033 1 00 0
00000001 00000002 00 00 0b 00000000 00 1 0 0 1 0 0 0 0 00000003 1 0b 0
aaaaaaaa 00000000 0c 0d 0e 00000000 00 1 0 0 1 0 0 0 1 aaaaaaaa 1 0e 0
55555555 00000001 0f 10 11 00000000 00 1 0 0 1 0 0 0 1 55555555 0 11 0
00000001 00000001 11 12 13 00000000 00 1 0 0 1 0 0 0 0 00000002 1 13 0
0000beef 00000000 14 13 15 00000000 00 1 0 0 1 0 0 0 2 0000beef 1 15 0
12345678 00000000 16 17 18 00000000 00 1 0 0 1 0 0 0 2 12345678 0 18 0
cafef00d 00000001 19 1a 1a 00000000 00 1 0 2 1 0 0 0 0 cafef00d 1 1a 0

// ==== project.f ====
hdl/isa_pkg.sv
hdl/exec_pkg.sv
hdl/operand_if.sv
hdl/pipe_stage.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/barrel_shifter.sv
hdl/result_merge.sv
hdl/exec_top.sv
bench/exec_props.sv
bench/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - hdl/isa_pkg.sv
  - hdl/exec_pkg.sv
  - hdl/operand_if.sv
  - hdl/pipe_stage.sv
  - hdl/operand_select.sv
  - hdl/alu.sv
  - hdl/barrel_shifter.sv
  - hdl/result_merge.sv
  - hdl/exec_top.sv
  - target: test
    files:
      - bench/exec_props.sv
      - bench/exec_tb.sv

// ==== bench/exec_tb.sv ====
module exec_tb;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    logic                req_ready;
    isa_pkg::data_t      req_op_a;
    isa_pkg::data_t      req_op_b;
    isa_pkg::reg_addr_t  req_rs_addr;
    isa_pkg::reg_addr_t  req_rt_addr;
    isa_pkg::reg_addr_t  req_rd_addr;
    isa_pkg::data_t      req_imm;
    isa_pkg::shamt_t     req_shamt;
    isa_pkg::alu_op_e    req_alu_op;
    isa_pkg::shift_op_e  req_shift_op;
    isa_pkg::exres_sel_e req_exres_sel;
    logic                req_reg_w;
    logic                req_ovf_disable;
    logic                req_imm_sel;
    logic                req_shamt_sel;
    isa_pkg::cmov_e      req_cmov;
    logic                res_valid;
    logic                res_ready;
    isa_pkg::data_t      res_data;
    isa_pkg::reg_addr_t  res_rd_addr;
    logic                res_reg_w;
    logic                res_overflow;

    exec_pkg::exec_req_t reqs[$];
    exec_pkg::exec_res_t exps[$];
    int                  n_lines = 0;

    exec_top exec_top_i (.*);

    bind exec_top exec_props exec_props_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_in    (req_in),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_q     (res_q)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input int line,
                              input isa_pkg::data_t got, input isa_pkg::data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s (trace entry %0d): got 0x%h, expected 0x%h",
                     name, line, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rd(input string name, input int line,
                            input isa_pkg::reg_addr_t got, input isa_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s (trace entry %0d): got 0x%h, expected 0x%h",
                     name, line, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input int line,
                              input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s (trace entry %0d): got 0x%h, expected 0x%h",
                     name, line, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Trace loading
    //////////////////////////////////////////////////////////////////////

    task automatic load_trace();
        int                  fd;
        int                  n;
        string               line;
        logic [31:0]         v_a, v_b, v_rs, v_rt, v_rd, v_imm, v_sh, v_aop;
        logic [31:0]         v_sop, v_sel, v_w, v_od, v_is, v_ss, v_cm;
        logic [31:0]         e_data, e_w, e_rd, e_ovf;
        exec_pkg::exec_req_t r;
        exec_pkg::exec_res_t e;
        fd = $fopen("bench/exec_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/exec_trace.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Blank lines and column notes
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_a, v_b, v_rs, v_rt, v_rd, v_imm, v_sh, v_aop, v_sop, v_sel,
                        v_w, v_od, v_is, v_ss, v_cm, e_data, e_w, e_rd, e_ovf);
            if (n != 19) begin
                $display("Trace line has %0d fields instead of 19: %s", n, line);
                abort_run();
            end
            r.op_a        = v_a;
            r.op_b        = v_b;
            r.rs_addr     = v_rs[4:0];
            r.rt_addr     = v_rt[4:0];
            r.rd_addr     = v_rd[4:0];
            r.imm         = v_imm;
            r.shamt       = v_sh[4:0];
            r.alu_op      = isa_pkg::alu_op_e'(v_aop[3:0]);
            r.shift_op    = isa_pkg::shift_op_e'(v_sop[1:0]);
            r.exres_sel   = isa_pkg::exres_sel_e'(v_sel[1:0]);
            r.reg_w       = v_w[0];
            r.ovf_disable = v_od[0];
            r.imm_sel     = v_is[0];
            r.shamt_sel   = v_ss[0];
            r.cmov        = isa_pkg::cmov_e'(v_cm[1:0]);
            e.data        = e_data;
            e.rd_addr     = e_rd[4:0];
            e.reg_w       = e_w[0];
            e.overflow    = e_ovf[0];
            reqs.push_back(r);
            exps.push_back(e);
        end
        $fclose(fd);
        if (reqs.size() == 0) begin
            $display("The trace file holds no requests");
            abort_run();
        end
        n_lines = reqs.size();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Driver and monitor
    //////////////////////////////////////////////////////////////////////

    task automatic apply_request(input exec_pkg::exec_req_t r);
        req_op_a        <= r.op_a;
        req_op_b        <= r.op_b;
        req_rs_addr     <= r.rs_addr;
        req_rt_addr     <= r.rt_addr;
        req_rd_addr     <= r.rd_addr;
        req_imm         <= r.imm;
        req_shamt       <= r.shamt;
        req_alu_op      <= r.alu_op;
        req_shift_op    <= r.shift_op;
        req_exres_sel   <= r.exres_sel;
        req_reg_w       <= r.reg_w;
        req_ovf_disable <= r.ovf_disable;
        req_imm_sel     <= r.imm_sel;
        req_shamt_sel   <= r.shamt_sel;
        req_cmov        <= r.cmov;
    endtask

    // Hold each request until the issue stage takes it
    task automatic drive_requests();
        for (int i = 0; i < n_lines; i++) begin
            req_valid <= 1'b1;
            apply_request(reqs[i]);
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;
    endtask

    task automatic collect_results();
        int idx;
        idx = 0;
        while (idx < n_lines) begin
            @(posedge clk);
            if (res_valid && res_ready) begin
                check_data("res_data", idx + 1, res_data, exps[idx].data);
                check_rd("res_rd_addr", idx + 1, res_rd_addr, exps[idx].rd_addr);
                check_flag("res_reg_w", idx + 1, res_reg_w, exps[idx].reg_w);
                check_flag("res_overflow", idx + 1, res_overflow, exps[idx].overflow);
                idx++;
            end
            // Ready about three cycles in four
            res_ready <= (($urandom % 4) != 0);
        end
        res_ready <= 1'b0;
    endtask

    initial begin : main_flow
        void'($urandom(24998));
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        res_ready = 1'b0;
        apply_request(exec_pkg::exec_req_t'('0));
        load_trace();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        fork
            drive_requests();
            collect_results();
        join
        $display("NO ERRORS");
        $finish;
    end

    // 40 cycles per trace entry is far above the worst back-pressure
    initial begin : watchdog
        wait (n_lines > 0);
        repeat (n_lines * 40) @(posedge clk);
        $display("Timeout: results stopped arriving within %0d cycles", n_lines * 40);
        abort_run();
    end

    initial begin : assertion_watch
        wait (exec_top_i.exec_props_i.failed === 1'b1);
        $display("A handshake assertion on the DUT failed");
        abort_run();
    end

endmodule

// ==== bench/exec_props.sv ====
module exec_props (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input logic                req_ready,
    input exec_pkg::exec_req_t req_in,
    input logic                res_valid,
    input logic                res_ready,
    input exec_pkg::exec_res_t res_q
);

    // Raised by any failing property
    logic failed = 1'b0;

    // Result stage empty right after reset
    res_empty_after_reset: assert property (
        @(posedge clk) !rst_n |=> !res_valid
    ) else begin
        $error("res_valid high in the cycle after reset");
        failed = 1'b1;
    end

    res_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_q)
    ) else begin
        $error("result channel changed while stalled");
        failed = 1'b1;
    end

    req_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_in)
    ) else begin
        $error("request channel changed while stalled");
        failed = 1'b1;
    end

endmodule

// ==== hdl/exec_top.sv ====
module exec_top (
    input  logic                clk,
    input  logic                rst_n,

    // Request channel
    input  logic                req_valid,
    output logic                req_ready,
    input  isa_pkg::data_t      req_op_a,
    input  isa_pkg::data_t      req_op_b,
    input  isa_pkg::reg_addr_t  req_rs_addr,
    input  isa_pkg::reg_addr_t  req_rt_addr,
    input  isa_pkg::reg_addr_t  req_rd_addr,
    input  isa_pkg::data_t      req_imm,
    input  isa_pkg::shamt_t     req_shamt,
    input  isa_pkg::alu_op_e    req_alu_op,
    input  isa_pkg::shift_op_e  req_shift_op,
    input  isa_pkg::exres_sel_e req_exres_sel,
    input  logic                req_reg_w,
    input  logic                req_ovf_disable,
    input  logic                req_imm_sel,
    input  logic                req_shamt_sel,
    input  isa_pkg::cmov_e      req_cmov,

    // Result channel
    output logic                res_valid,
    input  logic                res_ready,
    output isa_pkg::data_t      res_data,
    output isa_pkg::reg_addr_t  res_rd_addr,
    output logic                res_reg_w,
    output logic                res_overflow
);

    exec_pkg::exec_req_t req_in;
    exec_pkg::exec_req_t issue_q;
    logic                issue_valid;
    logic                merge_ready;
    exec_pkg::exec_res_t merged;
    exec_pkg::exec_res_t res_q;
    exec_pkg::fwd_rec_t  fwd_rec;
    isa_pkg::data_t      alu_result;
    logic                alu_overflow;
    isa_pkg::data_t      shift_result;

    operand_if ops_if ();

    assign req_in = '{
        op_a:        req_op_a,
        op_b:        req_op_b,
        rs_addr:     req_rs_addr,
        rt_addr:     req_rt_addr,
        rd_addr:     req_rd_addr,
        imm:         req_imm,
        shamt:       req_shamt,
        alu_op:      req_alu_op,
        shift_op:    req_shift_op,
        exres_sel:   req_exres_sel,
        reg_w:       req_reg_w,
        ovf_disable: req_ovf_disable,
        imm_sel:     req_imm_sel,
        shamt_sel:   req_shamt_sel,
        cmov:        req_cmov
    };

    //////////////////////////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////////////////////////

    pipe_stage #(.payload_t(exec_pkg::exec_req_t)) issue_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req_in),
        .out_valid (issue_valid),
        .out_ready (merge_ready),
        .out_data  (issue_q)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute datapath, ALU and shifter side by side
    //////////////////////////////////////////////////////////////////////

    operand_select operand_select_i (
        .req (issue_q),
        .fwd (fwd_rec),
        .ops (ops_if.source)
    );

    // Flags only feed branches, which live elsewhere
    alu alu_i (
        .ops      (ops_if.sink),
        .result   (alu_result),
        .less     (),
        .zero     (),
        .overflow (alu_overflow)
    );

    barrel_shifter barrel_shifter_i (
        .ops    (ops_if.sink),
        .result (shift_result)
    );

    result_merge result_merge_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ops          (ops_if.sink),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .shift_result (shift_result),
        .rd_addr      (issue_q.rd_addr),
        .load         (issue_valid && merge_ready),
        .res          (merged),
        .fwd          (fwd_rec)
    );

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    pipe_stage #(.payload_t(exec_pkg::exec_res_t)) result_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (issue_valid),
        .in_ready  (merge_ready),
        .in_data   (merged),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_q)
    );

    assign res_data     = res_q.data;
    assign res_rd_addr  = res_q.rd_addr;
    assign res_reg_w    = res_q.reg_w;
    assign res_overflow = res_q.overflow;

endmodule

// ==== hdl/result_merge.sv ====
module result_merge (
    input  logic                clk,
    input  logic                rst_n,
    operand_if.sink             ops,
    input  isa_pkg::data_t      alu_result,
    input  logic                alu_overflow,
    input  isa_pkg::data_t      shift_result,
    input  isa_pkg::reg_addr_t  rd_addr,
    input  logic                load,
    output exec_pkg::exec_res_t res,
    output exec_pkg::fwd_rec_t  fwd
);

    isa_pkg::data_t     data;
    logic               reg_w;
    logic               fwd_reg_w;
    isa_pkg::reg_addr_t fwd_rd_addr;
    isa_pkg::data_t     fwd_data;

    //////////////////////////////////////////////////////////////////////
    // Result selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ops.exres_sel)
            isa_pkg::EXRES_SHIFT:  data = shift_result;
            isa_pkg::EXRES_PASS_A: data = ops.fwd_a;
            default:               data = alu_result;
        endcase
    end

    // add, addi and sub drop the write on signed overflow
    assign reg_w = ops.write_gate && !(ops.ovf_disable && alu_overflow);

    assign res = '{data: data, rd_addr: rd_addr, reg_w: reg_w, overflow: alu_overflow};

    //////////////////////////////////////////////////////////////////////
    // Forwarding record
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_reg_w <= 1'b0;
        end else if (load) begin
            fwd_reg_w <= reg_w;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            fwd_rd_addr <= rd_addr;
            fwd_data    <= data;
        end
    end

    assign fwd = '{rd_addr: fwd_rd_addr, reg_w: fwd_reg_w, data: fwd_data};

endmodule

// ==== hdl/barrel_shifter.sv ====
module barrel_shifter (
    operand_if.sink        ops,
    output isa_pkg::data_t result
);

    localparam int STAGES = $clog2(isa_pkg::XLEN);

    logic           shift_left;
    isa_pkg::data_t fill_word;

    assign shift_left = (ops.shift_op == isa_pkg::SHIFT_SLL);

    // Vacated high bits take the sign only for sra
    assign fill_word = (ops.shift_op == isa_pkg::SHIFT_SRA) ?
                       {isa_pkg::XLEN{ops.fwd_b[isa_pkg::XLEN-1]}} : '0;

    // One stage per shamt bit, each by a power of two
    always_comb begin
        isa_pkg::data_t stage;
        stage = ops.fwd_b;
        for (int k = 0; k < STAGES; k++) begin
            if (ops.shamt[k]) begin
                if (shift_left) begin
                    stage = stage << (1 << k);
                end else begin
                    stage = (stage >> (1 << k)) |
                            (fill_word & ~({isa_pkg::XLEN{1'b1}} >> (1 << k)));
                end
            end
        end
        result = stage;
    end

endmodule

// ==== hdl/alu.sv ====
module alu (
    operand_if.sink        ops,
    output isa_pkg::data_t result,
    output logic           less,
    output logic           zero,
    output logic           overflow
);

    isa_pkg::data_t a;
    isa_pkg::data_t b;
    isa_pkg::data_t sum;
    isa_pkg::data_t diff;
    logic           add_ovf;
    logic           sub_ovf;
    logic           lt_signed;
    logic           lt_unsigned;

    assign a    = ops.op_a;
    assign b    = ops.op_b;
    assign sum  = a + b;
    assign diff = a - b;

    // Signs agree on input but result sign flips
    assign add_ovf = (a[isa_pkg::XLEN-1] == b[isa_pkg::XLEN-1]) &&
                     (sum[isa_pkg::XLEN-1] != a[isa_pkg::XLEN-1]);
    assign sub_ovf = (a[isa_pkg::XLEN-1] != b[isa_pkg::XLEN-1]) &&
                     (diff[isa_pkg::XLEN-1] != a[isa_pkg::XLEN-1]);

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (ops.alu_op)
            isa_pkg::ALU_ADD,
            isa_pkg::ALU_ADDU: result = sum;
            isa_pkg::ALU_SUB,
            isa_pkg::ALU_SUBU: result = diff;
            isa_pkg::ALU_AND:  result = a & b;
            isa_pkg::ALU_OR:   result = a | b;
            isa_pkg::ALU_XOR:  result = a ^ b;
            isa_pkg::ALU_NOR:  result = ~(a | b);
            isa_pkg::ALU_SLT:  result = isa_pkg::data_t'(lt_signed);
            isa_pkg::ALU_SLTU: result = isa_pkg::data_t'(lt_unsigned);
            isa_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:           result = sum;
        endcase
    end

    // Only the trapping forms report overflow
    always_comb begin
        case (ops.alu_op)
            isa_pkg::ALU_ADD: overflow = add_ovf;
            isa_pkg::ALU_SUB: overflow = sub_ovf;
            default:          overflow = 1'b0;
        endcase
    end

    assign less = (ops.alu_op == isa_pkg::ALU_SLTU) ? lt_unsigned : lt_signed;
    assign zero = (result == '0);

endmodule

// ==== hdl/operand_select.sv ====
module operand_select (
    input  exec_pkg::exec_req_t req,
    input  exec_pkg::fwd_rec_t  fwd,
    operand_if.source           ops
);

    logic           hit_a;
    logic           hit_b;
    logic           is_cmov;
    isa_pkg::data_t fwd_a;
    isa_pkg::data_t fwd_b;

    //////////////////////////////////////////////////////////////////////
    // Forwarding from the previous result
    //////////////////////////////////////////////////////////////////////

    // Register zero never matches
    assign hit_a = fwd.reg_w && (req.rs_addr != '0) && (req.rs_addr == fwd.rd_addr);
    assign hit_b = fwd.reg_w && (req.rt_addr != '0) && (req.rt_addr == fwd.rd_addr);

    assign fwd_a = hit_a ? fwd.data : req.op_a;
    assign fwd_b = hit_b ? fwd.data : req.op_b;

    assign ops.fwd_a = fwd_a;
    assign ops.fwd_b = fwd_b;

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////////////////////////

    assign is_cmov = (req.cmov != isa_pkg::CMOV_NONE);

    // Conditional move runs as rd <- 0 + rs, rt only tested
    assign ops.op_a = is_cmov ? '0 : fwd_a;

    always_comb begin
        if (req.imm_sel) begin
            ops.op_b = req.imm;
        end else if (is_cmov) begin
            ops.op_b = fwd_a;
        end else begin
            ops.op_b = fwd_b;
        end
    end

    // Variable shifts take rs[4:0]
    assign ops.shamt = req.shamt_sel ? fwd_a[4:0] : req.shamt;

    // Write enable before overflow suppression
    always_comb begin
        case (req.cmov)
            isa_pkg::CMOV_MOVZ: ops.write_gate = req.reg_w && (fwd_b == '0);
            isa_pkg::CMOV_MOVN: ops.write_gate = req.reg_w && (fwd_b != '0);
            default:            ops.write_gate = req.reg_w;
        endcase
    end

    assign ops.alu_op      = req.alu_op;
    assign ops.shift_op    = req.shift_op;
    assign ops.exres_sel   = req.exres_sel;
    assign ops.ovf_disable = req.ovf_disable;

endmodule

// ==== hdl/pipe_stage.sv ====
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // Free slot, or the held entry leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// ==== hdl/operand_if.sv ====
interface operand_if;

    isa_pkg::data_t      op_a;
    isa_pkg::data_t      op_b;
    isa_pkg::data_t      fwd_a;
    isa_pkg::data_t      fwd_b;
    isa_pkg::shamt_t     shamt;
    isa_pkg::alu_op_e    alu_op;
    isa_pkg::shift_op_e  shift_op;
    isa_pkg::exres_sel_e exres_sel;
    logic                write_gate;
    logic                ovf_disable;

    modport source (
        output op_a, op_b, fwd_a, fwd_b, shamt,
        output alu_op, shift_op, exres_sel, write_gate, ovf_disable
    );

    modport sink (
        input op_a, op_b, fwd_a, fwd_b, shamt,
        input alu_op, shift_op, exres_sel, write_gate, ovf_disable
    );

endinterface

// ==== hdl/exec_pkg.sv ====
package exec_pkg;

    // One execute request, operands already read from the register file
    typedef struct packed {
        isa_pkg::data_t     op_a;
        isa_pkg::data_t     op_b;
        isa_pkg::reg_addr_t rs_addr;
        isa_pkg::reg_addr_t rt_addr;
        isa_pkg::reg_addr_t rd_addr;
        isa_pkg::data_t     imm;
        isa_pkg::shamt_t    shamt;
        isa_pkg::alu_op_e   alu_op;
        isa_pkg::shift_op_e shift_op;
        isa_pkg::exres_sel_e exres_sel;
        logic               reg_w;
        logic               ovf_disable;
        logic               imm_sel;
        logic               shamt_sel;
        isa_pkg::cmov_e     cmov;
    } exec_req_t;

    // Register-write result leaving the stage
    typedef struct packed {
        isa_pkg::data_t     data;
        isa_pkg::reg_addr_t rd_addr;
        logic               reg_w;
        logic               overflow;
    } exec_res_t;

    // Last merged result, seen by the next request
    typedef struct packed {
        isa_pkg::reg_addr_t rd_addr;
        logic               reg_w;
        isa_pkg::data_t     data;
    } fwd_rec_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Machine word and register numbers
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [4:0]      shamt_t;

    //////////////////////////////////////////////////////////////////////
    // Execute stage control codes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        SHIFT_SLL = 2'd0,
        SHIFT_SRL = 2'd1,
        SHIFT_SRA = 2'd2
    } shift_op_e;

    // Pass_a hands back operand A after forwarding
    typedef enum logic [1:0] {
        EXRES_ALU    = 2'd0,
        EXRES_SHIFT  = 2'd1,
        EXRES_PASS_A = 2'd2
    } exres_sel_e;

    typedef enum logic [1:0] {
        CMOV_NONE = 2'd0,
        CMOV_MOVZ = 2'd1,
        CMOV_MOVN = 2'd2
    } cmov_e;

endpackage
